/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --top-module trap_unit_tb -f sources.f -o trap_unit_sim
	@out="$$(./obj_dir/trap_unit_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "test passed"

clean:
	rm -rf obj_dir

/* dv/tb_clock_gen.sv */
// ================================================
// testbench clock (period 4) and reset held for
// the first three rising edges
// ================================================
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (3) @(posedge o_clk);
    @(negedge o_clk);  // release away from the sampling edge
    o_rst = 1'b0;
  end

endmodule

`default_nettype wire

/* dv/trap_unit_tb.sv */
// ================================================
// table-driven testbench for the trap unit with a
// CSR model; build with sources.f as top module
// ================================================
`default_nettype none

`include "trap_defs.svh"

module trap_unit_tb;

  localparam int NUM_FIXED      = 10;
  localparam int NUM_RANDOM     = 24;
  localparam int NUM_ROWS       = NUM_FIXED + NUM_RANDOM;
  localparam int CYCLE_LIMIT    = 20 * NUM_ROWS * 30;
  localparam int ENTRY_LATENCY  = 12;
  localparam int RETURN_LATENCY = 9;

  localparam logic [1:0] KIND_NONE   = 2'd0;
  localparam logic [1:0] KIND_ENTRY  = 2'd1;
  localparam logic [1:0] KIND_RETURN = 2'd2;

  typedef struct packed {
    trap_pkg::xword_t  mtvec;
    trap_pkg::xword_t  mstatus;
    trap_pkg::opcode_t opcode;
    logic              timer;
    logic              valid;
    trap_pkg::xword_t  pc;
    logic [3:0]        ack_delay;
    logic [1:0]        kind;
  } row_t;

  wire clk;
  wire rst;

  logic                valid;
  trap_pkg::opcode_t   opcode;
  logic                timer_irq;
  trap_pkg::xword_t    pc;
  logic                ack;
  logic                host_wen;
  trap_pkg::csr_addr_t host_addr;
  trap_pkg::xword_t    host_wdata;
  logic                redirect;
  trap_pkg::xword_t    redirect_pc;
  logic                done;

  // model copies of the machine CSRs
  trap_pkg::xword_t exp_mepc;
  trap_pkg::xword_t exp_mcause;
  trap_pkg::xword_t exp_mtvec;
  trap_pkg::xword_t exp_mstatus;

  row_t rows[$];
  int   cycles = 0;

  tb_clock_gen u_clk (
    .o_clk (clk),
    .o_rst (rst)
  );

  trap_unit_top DUT (
    .clk           (clk),
    .rst           (rst),
    .i_valid       (valid),
    .i_opcode      (opcode),
    .i_timer_irq   (timer_irq),
    .i_pc          (pc),
    .i_ack         (ack),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .o_done        (done),
    .i_host_wen    (host_wen),
    .i_host_addr   (host_addr),
    .i_host_wdata  (host_wdata)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  function automatic row_t make_row(input trap_pkg::xword_t mtvec,
                                    input trap_pkg::xword_t mstatus,
                                    input trap_pkg::opcode_t op,
                                    input logic timer,
                                    input logic req_valid,
                                    input trap_pkg::xword_t req_pc,
                                    input logic [3:0] delay,
                                    input logic [1:0] kind);
    row_t r;
    r.mtvec     = mtvec;
    r.mstatus   = mstatus;
    r.opcode    = op;
    r.timer     = timer;
    r.valid     = req_valid;
    r.pc        = req_pc;
    r.ack_delay = delay;
    r.kind      = kind;
    return r;
  endfunction

  // request selection, first match wins
  function automatic logic [1:0] classify(input logic req_valid,
                                          input trap_pkg::opcode_t op,
                                          input logic timer);
    if (!req_valid) return KIND_NONE;
    if (op == `TRAP_OP_ECALL) return KIND_ENTRY;
    if (timer) return KIND_ENTRY;
    if (op == `TRAP_OP_MRET) return KIND_RETURN;
    return KIND_NONE;
  endfunction

  task automatic load_table();
    rows.push_back(make_row(64'h8000_1000, 64'h0, `TRAP_OP_ECALL, 1'b0, 1'b1,
                            64'h1_0000_0040, 4'd0, KIND_ENTRY));
    rows.push_back(make_row(64'h8000_2000, 64'h8, 8'h00, 1'b1, 1'b1,
                            64'h2000_0104, 4'd3, KIND_ENTRY));
    rows.push_back(make_row(64'h8000_3000, 64'h80, `TRAP_OP_ECALL, 1'b1, 1'b1,
                            64'hdead_beef_0000_1234, 4'd1, KIND_ENTRY));  // ecall over timer
    rows.push_back(make_row(64'h4000, 64'h1888, `TRAP_OP_MRET, 1'b1, 1'b1,
                            64'h7777_0000, 4'd2, KIND_ENTRY));  // timer over mret
    rows.push_back(make_row(64'h1234, 64'h80, `TRAP_OP_MRET, 1'b0, 1'b1,
                            64'h0, 4'd4, KIND_RETURN));
    rows.push_back(make_row(64'h5678, 64'h0, `TRAP_OP_MRET, 1'b0, 1'b1,
                            64'h0, 4'd0, KIND_RETURN));
    rows.push_back(make_row(64'h9000, 64'h1800, 8'h33, 1'b0, 1'b1,
                            64'h3000_0000, 4'd0, KIND_NONE));
    rows.push_back(make_row(64'h9100, 64'h0, `TRAP_OP_ECALL, 1'b1, 1'b0,
                            64'h3000_0010, 4'd0, KIND_NONE));  // no strobe
    rows.push_back(make_row(64'hffff_ffff_ffff_fffc, 64'h0, `TRAP_OP_ECALL, 1'b0, 1'b1,
                            64'h0000_0000_0040_0000, 4'd8, KIND_ENTRY));
    rows.push_back(make_row(64'h2_0000_0000, 64'h88, 8'hff, 1'b1, 1'b1,
                            64'h8000_0000_0000_0010, 4'd5, KIND_ENTRY));
  endtask

  task automatic add_random_rows();
    row_t r;
    int   n;
    int   sel;
    for (n = 0; n < NUM_RANDOM; n++) begin
      sel         = $urandom_range(2, 0);
      r.mtvec     = {$urandom(), $urandom()};
      r.mstatus   = {$urandom(), $urandom()};
      r.pc        = {$urandom(), $urandom()};
      r.timer     = ($urandom_range(3, 0) == 0);
      r.valid     = 1'b1;
      r.ack_delay = 4'($urandom_range(7, 0));
      case (sel)
        0:       r.opcode = `TRAP_OP_ECALL;
        1:       r.opcode = `TRAP_OP_MRET;
        default: r.opcode = 8'h10 | 8'($urandom_range(15, 0));  // never ecall or mret
      endcase
      r.kind = classify(r.valid, r.opcode, r.timer);
      rows.push_back(r);
    end
  endtask

  // all stimulus tasks start and end at a falling edge
  task automatic host_write(input trap_pkg::csr_addr_t addr, input trap_pkg::xword_t data);
    host_wen   = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(negedge clk);
    host_wen = 1'b0;
    case (addr)
      `TRAP_CSR_MTVEC:   exp_mtvec   = data;
      `TRAP_CSR_MSTATUS: exp_mstatus = data;
      default: ;
    endcase
  endtask

  task automatic issue_request(input logic req_valid, input trap_pkg::opcode_t op,
                               input logic timer, input trap_pkg::xword_t req_pc);
    valid     = req_valid;
    opcode    = op;
    timer_irq = timer;
    pc        = req_pc;
    @(negedge clk);
    valid     = 1'b0;
    opcode    = '0;
    timer_irq = 1'b0;
  endtask

  task automatic check_csrs();
    check_value("mepc", DUT.u_csr.mepc, exp_mepc);
    check_value("mcause", DUT.u_csr.mcause, exp_mcause);
    check_value("mtvec", DUT.u_csr.mtvec, exp_mtvec);
    check_value("mstatus", DUT.u_csr.mstatus, exp_mstatus);
  endtask

  task automatic expect_quiet(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(negedge clk);
      check_value("o_redirect", 64'(redirect), 64'd0);
      check_value("o_done", 64'(done), 64'd0);
    end
  endtask

  // count edges from the strobe edge until the redirect shows
  task automatic wait_redirect(input int latency, input trap_pkg::xword_t exp_pc);
    int count;
    count = 0;
    while (!redirect) begin
      check_value("o_done", 64'(done), 64'd0);
      if (count > latency + 4) begin
        $display("no redirect within %0d cycles of the request", latency + 4);
        $display("test failed");
        $fatal(1);
      end
      @(negedge clk);
      count++;
    end
    check_value("redirect latency", 64'(count), 64'(latency));
    check_value("o_redirect_pc", redirect_pc, exp_pc);
    check_value("o_done", 64'(done), 64'd1);
  endtask

  // hold ack off, poke a strobe that must be dropped, then ack
  task automatic finish_handshake(input logic [3:0] delay);
    int i;
    for (i = 0; i < int'(delay); i++) begin
      valid  = (i == 0);
      opcode = `TRAP_OP_ECALL;
      pc     = 64'hffff_0000_dead_0000;
      @(negedge clk);
      check_value("o_done", 64'(done), 64'd1);
      check_value("o_redirect", 64'(redirect), 64'd0);
    end
    valid  = 1'b0;
    opcode = '0;
    ack    = 1'b1;
    @(negedge clk);
    ack = 1'b0;
    check_value("o_done", 64'(done), 64'd0);
    check_value("o_redirect", 64'(redirect), 64'd0);
    if (delay != 4'd0) begin
      expect_quiet(13);
    end
  endtask

  task automatic expect_entry(input trap_pkg::opcode_t op, input trap_pkg::xword_t req_pc,
                              input logic [3:0] delay);
    wait_redirect(ENTRY_LATENCY, exp_mtvec);
    exp_mepc = req_pc;
    if (op == `TRAP_OP_ECALL) begin
      exp_mcause  = 64'd11;
      exp_mstatus = 64'h1800;
    end else begin
      exp_mcause  = 64'h8000_0000_0000_0007;
      exp_mstatus = 64'h1880;
    end
    finish_handshake(delay);
    check_csrs();
  endtask

  task automatic expect_return(input logic [3:0] delay);
    trap_pkg::xword_t next_status;
    wait_redirect(RETURN_LATENCY, exp_mepc);
    next_status = 64'h80;
    if (exp_mstatus[7]) begin
      next_status = next_status | 64'h8;  // MIE takes old MPIE
    end
    exp_mstatus = next_status;
    finish_handshake(delay);
    check_csrs();
  endtask

  task automatic run_row(input row_t r);
    host_write(`TRAP_CSR_MTVEC, r.mtvec);
    host_write(`TRAP_CSR_MSTATUS, r.mstatus);
    issue_request(r.valid, r.opcode, r.timer, r.pc);
    case (r.kind)
      KIND_ENTRY: begin
        expect_entry(r.opcode, r.pc, r.ack_delay);
        issue_request(1'b1, `TRAP_OP_MRET, 1'b0, 64'h0);
        expect_return(4'd0);
        issue_request(1'b1, `TRAP_OP_MRET, 1'b0, 64'h0);
        expect_return(4'd1);
      end
      KIND_RETURN: expect_return(r.ack_delay);
      default:     expect_quiet(15);
    endcase
  endtask

  initial begin
    int idx;
    valid       = 1'b0;
    opcode      = '0;
    timer_irq   = 1'b0;
    pc          = '0;
    ack         = 1'b0;
    host_wen    = 1'b0;
    host_addr   = '0;
    host_wdata  = '0;
    exp_mepc    = '0;
    exp_mcause  = '0;
    exp_mtvec   = '0;
    exp_mstatus = '0;
    void'($urandom(56567));
    load_table();
    add_random_rows();

    @(negedge clk);
    while (rst) @(negedge clk);
    @(negedge clk);

    // state straight out of reset
    check_value("o_done", 64'(done), 64'd0);
    check_value("o_redirect", 64'(redirect), 64'd0);
    check_csrs();
    issue_request(1'b1, `TRAP_OP_MRET, 1'b0, 64'h0);
    expect_return(4'd0);

    for (idx = 0; idx < rows.size(); idx++) begin
      run_row(rows[idx]);
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/trap_pkg.sv
src/machine_csr_file.sv
src/trap_sequencer.sv
src/trap_unit_top.sv
dv/tb_clock_gen.sv
dv/trap_unit_tb.sv

/* src/machine_csr_file.sv */
// ================================================
// mepc, mcause, mtvec and mstatus with a sequencer
// port and a host write port for setup
// ================================================
`default_nettype none

`include "trap_defs.svh"

module machine_csr_file (
  input  wire                       clk,
  input  wire                       rst,
  input  wire trap_pkg::csr_addr_t  i_addr,
  input  wire                       i_ren,
  input  wire                       i_wen,
  input  wire trap_pkg::xword_t     i_wdata,
  input  wire                       i_host_wen,
  input  wire trap_pkg::csr_addr_t  i_host_addr,
  input  wire trap_pkg::xword_t     i_host_wdata,
  output trap_pkg::xword_t          o_rdata
);

  trap_pkg::xword_t mepc;
  trap_pkg::xword_t mcause;
  trap_pkg::xword_t mtvec;
  trap_pkg::xword_t mstatus;

  logic                wr_en;
  trap_pkg::csr_addr_t wr_addr;
  trap_pkg::xword_t    wr_data;
  trap_pkg::xword_t    rd_mux;

  // sequencer owns the write port when both ask
  assign wr_en   = i_wen || i_host_wen;
  assign wr_addr = i_wen ? i_addr : i_host_addr;
  assign wr_data = i_wen ? i_wdata : i_host_wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      mepc    <= '0;
      mcause  <= '0;
      mtvec   <= '0;
      mstatus <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        `TRAP_CSR_MEPC:    mepc    <= wr_data;
        `TRAP_CSR_MCAUSE:  mcause  <= wr_data;
        `TRAP_CSR_MTVEC:   mtvec   <= wr_data;
        `TRAP_CSR_MSTATUS: mstatus <= wr_data;
        default: ;  // unknown address dropped
      endcase
    end
  end

  always_comb begin
    case (i_addr)
      `TRAP_CSR_MEPC:    rd_mux = mepc;
      `TRAP_CSR_MCAUSE:  rd_mux = mcause;
      `TRAP_CSR_MTVEC:   rd_mux = mtvec;
      `TRAP_CSR_MSTATUS: rd_mux = mstatus;
      default:           rd_mux = '0;
    endcase
  end

  // registered read, data shows the cycle after i_ren
  always_ff @(posedge clk) begin
    if (i_ren) begin
      o_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

/* src/trap_defs.svh */
// ================================================
// widths, CSR addresses and trap constants shared by
// the trap unit; include once per file
// ================================================
`ifndef TRAP_DEFS_SVH
`define TRAP_DEFS_SVH

// data and CSR address widths
`define TRAP_XLEN   64
`define TRAP_CSR_AW 12

// machine CSR addresses
`define TRAP_CSR_MSTATUS 12'h300
`define TRAP_CSR_MTVEC   12'h305
`define TRAP_CSR_MEPC    12'h341
`define TRAP_CSR_MCAUSE  12'h342

// opcode codes from the core decoder
`define TRAP_OP_ECALL 8'h01
`define TRAP_OP_MRET  8'h02

`define TRAP_CAUSE_ECALL 64'd11
`define TRAP_CAUSE_TIMER 64'h8000_0000_0000_0007  // interrupt bit plus 7

// mstatus values written on entry, MPP = machine
`define TRAP_MSTATUS_ECALL 64'h1800
`define TRAP_MSTATUS_TIMER 64'h1880  // also MPIE
`define TRAP_MSTATUS_MPIE_BIT 7
`define TRAP_MSTATUS_MIE_BIT  3

`endif

/* src/trap_pkg.sv */
// ================================================
// types for the trap unit, referenced by scoped name
// ================================================
`default_nettype none

`include "trap_defs.svh"

package trap_pkg;

  typedef logic [`TRAP_XLEN-1:0]   xword_t;
  typedef logic [`TRAP_CSR_AW-1:0] csr_addr_t;
  typedef logic [7:0]              opcode_t;

  typedef enum logic [2:0] {
    IDLE,
    ENTER_WR_MEPC,
    ENTER_WR_MCAUSE,
    ENTER_RD_MTVEC,
    ENTER_WR_MSTATUS,
    LEAVE_RD_MSTATUS,
    LEAVE_RD_MEPC,
    LEAVE_WR_MSTATUS
  } trap_state_t;

endpackage

`default_nettype wire

/* src/trap_sequencer.sv */
// ================================================
// trap entry / mret sequencer, walks CSR phases of
// three cycles each then redirects the pc
// ================================================
`default_nettype none

`include "trap_defs.svh"

module trap_sequencer (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_valid,
  input  wire trap_pkg::opcode_t    i_opcode,
  input  wire                       i_timer_irq,
  input  wire trap_pkg::xword_t     i_pc,
  input  wire                       i_ack,
  input  wire trap_pkg::xword_t     i_csr_rdata,
  output trap_pkg::csr_addr_t       o_csr_addr,
  output logic                      o_csr_ren,
  output logic                      o_csr_wen,
  output trap_pkg::xword_t          o_csr_wdata,
  output logic                      o_redirect,
  output trap_pkg::xword_t          o_redirect_pc,
  output logic                      o_done
);

  trap_pkg::trap_state_t state;
  trap_pkg::trap_state_t next_phase;
  logic [1:0]            step;

  logic accept;
  logic take_ecall;
  logic take_entry;
  logic phase_end;
  logic last_phase;

  trap_pkg::xword_t cause;
  trap_pkg::xword_t entry_mstatus;
  trap_pkg::xword_t saved_pc;
  trap_pkg::xword_t rdata_save1;     // mtvec on entry, mstatus on return
  trap_pkg::xword_t rdata_save2;     // mepc on return
  trap_pkg::xword_t return_mstatus;

  assign accept     = (state == trap_pkg::IDLE) && i_valid && !o_done;
  assign take_ecall = (i_opcode == `TRAP_OP_ECALL);
  assign take_entry = take_ecall || i_timer_irq;  // ecall beats timer
  assign phase_end  = (step == 2'd2);
  assign last_phase = phase_end && ((state == trap_pkg::ENTER_WR_MSTATUS) ||
                                    (state == trap_pkg::LEAVE_WR_MSTATUS));

  always_comb begin
    case (state)
      trap_pkg::ENTER_WR_MEPC:    next_phase = trap_pkg::ENTER_WR_MCAUSE;
      trap_pkg::ENTER_WR_MCAUSE:  next_phase = trap_pkg::ENTER_RD_MTVEC;
      trap_pkg::ENTER_RD_MTVEC:   next_phase = trap_pkg::ENTER_WR_MSTATUS;
      trap_pkg::LEAVE_RD_MSTATUS: next_phase = trap_pkg::LEAVE_RD_MEPC;
      trap_pkg::LEAVE_RD_MEPC:    next_phase = trap_pkg::LEAVE_WR_MSTATUS;
      default:                    next_phase = trap_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= trap_pkg::IDLE;
      step  <= 2'd0;
    end else if (state == trap_pkg::IDLE) begin
      step <= 2'd0;
      if (accept) begin
        if (take_entry) begin
          state <= trap_pkg::ENTER_WR_MEPC;
        end else if (i_opcode == `TRAP_OP_MRET) begin
          state <= trap_pkg::LEAVE_RD_MSTATUS;
        end
      end
    end else if (phase_end) begin
      state <= next_phase;
      step  <= 2'd0;
    end else begin
      step <= step + 2'd1;
    end
  end

  // inputs last one cycle, so latch them at the strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      saved_pc <= i_pc;
      if (take_ecall) begin
        cause         <= `TRAP_CAUSE_ECALL;
        entry_mstatus <= `TRAP_MSTATUS_ECALL;
      end else begin
        cause         <= `TRAP_CAUSE_TIMER;
        entry_mstatus <= `TRAP_MSTATUS_TIMER;
      end
    end
  end

  // rdata is valid in step 1 of a read phase
  always_ff @(posedge clk) begin
    if (step == 2'd1) begin
      case (state)
        trap_pkg::ENTER_RD_MTVEC,
        trap_pkg::LEAVE_RD_MSTATUS: rdata_save1 <= i_csr_rdata;
        trap_pkg::LEAVE_RD_MEPC:    rdata_save2 <= i_csr_rdata;
        default: ;
      endcase
    end
  end

  // MPIE set, MIE takes the old MPIE
  always_comb begin
    return_mstatus = '0;
    return_mstatus[`TRAP_MSTATUS_MPIE_BIT] = 1'b1;
    return_mstatus[`TRAP_MSTATUS_MIE_BIT]  = rdata_save1[`TRAP_MSTATUS_MPIE_BIT];
  end

  always_comb begin
    o_csr_addr  = '0;
    o_csr_ren   = 1'b0;
    o_csr_wen   = 1'b0;
    o_csr_wdata = '0;
    if (step == 2'd0) begin  // strobe only in the first cycle of a phase
      case (state)
        trap_pkg::ENTER_WR_MEPC: begin
          o_csr_addr  = `TRAP_CSR_MEPC;
          o_csr_wen   = 1'b1;
          o_csr_wdata = saved_pc;
        end
        trap_pkg::ENTER_WR_MCAUSE: begin
          o_csr_addr  = `TRAP_CSR_MCAUSE;
          o_csr_wen   = 1'b1;
          o_csr_wdata = cause;
        end
        trap_pkg::ENTER_RD_MTVEC: begin
          o_csr_addr = `TRAP_CSR_MTVEC;
          o_csr_ren  = 1'b1;
        end
        trap_pkg::ENTER_WR_MSTATUS: begin
          o_csr_addr  = `TRAP_CSR_MSTATUS;
          o_csr_wen   = 1'b1;
          o_csr_wdata = entry_mstatus;
        end
        trap_pkg::LEAVE_RD_MSTATUS: begin
          o_csr_addr = `TRAP_CSR_MSTATUS;
          o_csr_ren  = 1'b1;
        end
        trap_pkg::LEAVE_RD_MEPC: begin
          o_csr_addr = `TRAP_CSR_MEPC;
          o_csr_ren  = 1'b1;
        end
        trap_pkg::LEAVE_WR_MSTATUS: begin
          o_csr_addr  = `TRAP_CSR_MSTATUS;
          o_csr_wen   = 1'b1;
          o_csr_wdata = return_mstatus;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_redirect <= 1'b0;
      o_done     <= 1'b0;
    end else begin
      o_redirect <= last_phase;  // single cycle pulse
      if (last_phase) begin
        o_done <= 1'b1;
      end else if (i_ack) begin
        o_done <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (last_phase) begin
      o_redirect_pc <= (state == trap_pkg::ENTER_WR_MSTATUS) ? rdata_save1 : rdata_save2;
    end
  end

endmodule

`default_nettype wire

/* src/trap_unit_top.sv */
// ================================================
// trap unit top: sequencer plus machine CSR file
// ================================================
`default_nettype none

module trap_unit_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       i_valid,
  input  wire trap_pkg::opcode_t    i_opcode,
  input  wire                       i_timer_irq,
  input  wire trap_pkg::xword_t     i_pc,
  input  wire                       i_ack,
  output logic                      o_redirect,
  output trap_pkg::xword_t          o_redirect_pc,
  output logic                      o_done,
  input  wire                       i_host_wen,
  input  wire trap_pkg::csr_addr_t  i_host_addr,
  input  wire trap_pkg::xword_t     i_host_wdata
);

  trap_pkg::csr_addr_t csr_addr;
  logic                csr_ren;
  logic                csr_wen;
  trap_pkg::xword_t    csr_wdata;
  trap_pkg::xword_t    csr_rdata;

  trap_sequencer u_seq (
    .clk           (clk),
    .rst           (rst),
    .i_valid       (i_valid),
    .i_opcode      (i_opcode),
    .i_timer_irq   (i_timer_irq),
    .i_pc          (i_pc),
    .i_ack         (i_ack),
    .i_csr_rdata   (csr_rdata),
    .o_csr_addr    (csr_addr),
    .o_csr_ren     (csr_ren),
    .o_csr_wen     (csr_wen),
    .o_csr_wdata   (csr_wdata),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc),
    .o_done        (o_done)
  );

  machine_csr_file u_csr (
    .clk          (clk),
    .rst          (rst),
    .i_addr       (csr_addr),
    .i_ren        (csr_ren),
    .i_wen        (csr_wen),
    .i_wdata      (csr_wdata),
    .i_host_wen   (i_host_wen),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .o_rdata      (csr_rdata)
  );

endmodule

`default_nettype wire
